//--- rtl/mips_pkg.sv
package mips_pkg;

    // ==================================================
    // widths
    // ==================================================
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [2:0]  alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;
    localparam alu_op_t ALU_LUI = 3'd5;

    // primary opcodes.
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

    // ==================================================
    // stage bundles
    // ==================================================
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_t   alu_op;
        word_t     a;
        word_t     b;
        word_t     store_data;
        logic      reg_write;
        reg_addr_t wreg;
        logic      mem_read;
        logic      mem_write;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     result;     // address for lw/sw.
        word_t     store_data;
        logic      reg_write;
        reg_addr_t wreg;
        logic      mem_read;
        logic      mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      reg_write;
        reg_addr_t wreg;
        word_t     data;
    } mem_wb_t;

endpackage

//--- rtl/mips_fetch.sv
`timescale 1ns/1ps

module mips_fetch #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc00000
) (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            freeze_i,
    input  logic            hold_i,
    input  logic            branch_taken_i,
    input  mips_pkg::word_t branch_target_i,
    input  mips_pkg::inst_t inst_rdata_i,
    output mips_pkg::word_t inst_addr_o,
    output mips_pkg::word_t id_pc_o,
    output mips_pkg::inst_t id_inst_o,
    output logic            id_valid_o
);

    mips_pkg::word_t pc;
    logic            advance;

    assign advance     = !freeze_i && !hold_i;
    assign inst_addr_o = pc;

    // redirect lands after the delay slot is captured below.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc         <= RESET_PC;
            id_valid_o <= 1'b0;
        end else if (advance) begin
            pc         <= branch_taken_i ? branch_target_i : pc + 32'd4;
            id_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            id_pc_o   <= pc;
            id_inst_o <= inst_rdata_i;
        end
    end

endmodule

//--- rtl/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                we_i,
    input  mips_pkg::reg_addr_t waddr_i,
    input  mips_pkg::word_t     wdata_i,
    input  mips_pkg::reg_addr_t raddr_a_i,
    input  mips_pkg::reg_addr_t raddr_b_i,
    output mips_pkg::word_t     rdata_a_o,
    output mips_pkg::word_t     rdata_b_o
);

    mips_pkg::word_t [31:0] regs;   // entry 0 never written.

    function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr,
                                                  input logic we,
                                                  input mips_pkg::reg_addr_t waddr,
                                                  input mips_pkg::word_t wdata,
                                                  input mips_pkg::word_t [31:0] rf);
        // writeback bypass.
        if (we && waddr == addr && addr != '0)
            return wdata;
        return rf[addr];
    endfunction

    assign rdata_a_o = read_port(raddr_a_i, we_i, waddr_i, wdata_i, regs);
    assign rdata_b_o = read_port(raddr_b_i, we_i, waddr_i, wdata_i, regs);

    always_ff @(posedge clk) begin
        if (rst_i)
            regs <= '0;
        else if (we_i && waddr_i != '0)
            regs[waddr_i] <= wdata_i;
    end

endmodule

//--- rtl/mips_decode.sv
`timescale 1ns/1ps

module mips_decode (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                freeze_i,
    input  mips_pkg::word_t     pc_i,
    input  mips_pkg::inst_t     inst_i,
    input  logic                valid_i,
    input  mips_pkg::word_t     rs_data_i,
    input  mips_pkg::word_t     rt_data_i,
    output mips_pkg::reg_addr_t rs_addr_o,
    output mips_pkg::reg_addr_t rt_addr_o,
    input  mips_pkg::fwd_t      ex_fwd_i,
    input  mips_pkg::fwd_t      mem_fwd_i,
    input  logic                ex_load_i,
    input  mips_pkg::reg_addr_t ex_load_reg_i,
    output logic                hold_o,
    output logic                branch_taken_o,
    output mips_pkg::word_t     branch_target_o,
    output mips_pkg::id_ex_t    id_ex_o
);

    mips_pkg::opcode_t   op;
    mips_pkg::funct_t    fn;
    mips_pkg::reg_addr_t rd;
    mips_pkg::word_t     imm_sext;
    mips_pkg::word_t     imm_zext;
    mips_pkg::word_t     rs_val;
    mips_pkg::word_t     rt_val;
    logic                uses_rs;
    logic                uses_rt;
    logic                is_beq;
    logic                is_bne;
    mips_pkg::id_ex_t    nxt;

    // execute is the younger producer and wins.
    function automatic mips_pkg::word_t fwd_sel(input mips_pkg::reg_addr_t addr,
                                                input mips_pkg::word_t rf_data,
                                                input mips_pkg::fwd_t ex_f,
                                                input mips_pkg::fwd_t mem_f);
        if (ex_f.we && ex_f.addr == addr && addr != '0)
            return ex_f.data;
        if (mem_f.we && mem_f.addr == addr && addr != '0)
            return mem_f.data;
        return rf_data;
    endfunction

    assign op        = inst_i[31:26];
    assign fn        = inst_i[5:0];
    assign rd        = inst_i[15:11];
    assign rs_addr_o = inst_i[25:21];
    assign rt_addr_o = inst_i[20:16];
    assign imm_sext  = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_zext  = {16'h0000, inst_i[15:0]};

    assign rs_val = fwd_sel(rs_addr_o, rs_data_i, ex_fwd_i, mem_fwd_i);
    assign rt_val = fwd_sel(rt_addr_o, rt_data_i, ex_fwd_i, mem_fwd_i);

    assign is_beq  = op == mips_pkg::OP_BEQ;
    assign is_bne  = op == mips_pkg::OP_BNE;
    assign uses_rs = op != mips_pkg::OP_LUI;
    assign uses_rt = op == mips_pkg::OP_SPECIAL || op == mips_pkg::OP_SW || is_beq || is_bne;

    // ==================================================
    // load-use and branch
    // ==================================================
    assign hold_o = valid_i && ex_load_i && ex_load_reg_i != '0 &&
                    ((uses_rs && rs_addr_o == ex_load_reg_i) ||
                     (uses_rt && rt_addr_o == ex_load_reg_i));

    assign branch_target_o = pc_i + 32'd4 + {imm_sext[29:0], 2'b00};
    assign branch_taken_o  = valid_i && !hold_o &&
                             ((is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val));

    always_comb begin
        nxt            = '0;
        nxt.valid      = valid_i && !hold_o;   // bubble on load-use.
        nxt.pc         = pc_i;
        nxt.alu_op     = mips_pkg::ALU_ADD;
        nxt.a          = rs_val;
        nxt.b          = imm_sext;
        nxt.store_data = rt_val;
        nxt.wreg       = rt_addr_o;
        case (op)
            mips_pkg::OP_SPECIAL: begin
                nxt.b         = rt_val;
                nxt.wreg      = rd;
                nxt.reg_write = 1'b1;
                case (fn)
                    mips_pkg::FN_ADDU: nxt.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: nxt.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  nxt.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   nxt.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT:  nxt.alu_op = mips_pkg::ALU_SLT;
                    default:           nxt.reg_write = 1'b0;   // nop and unsupported.
                endcase
            end
            mips_pkg::OP_ADDIU: nxt.reg_write = 1'b1;
            mips_pkg::OP_ORI: begin
                nxt.alu_op    = mips_pkg::ALU_OR;
                nxt.b         = imm_zext;
                nxt.reg_write = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                nxt.alu_op    = mips_pkg::ALU_LUI;
                nxt.b         = imm_zext;
                nxt.reg_write = 1'b1;
            end
            mips_pkg::OP_LW: begin
                nxt.reg_write = 1'b1;
                nxt.mem_read  = 1'b1;
            end
            mips_pkg::OP_SW: nxt.mem_write = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_ex_o.valid     <= 1'b0;
            id_ex_o.reg_write <= 1'b0;
            id_ex_o.mem_read  <= 1'b0;
            id_ex_o.mem_write <= 1'b0;
        end else if (!freeze_i) begin
            id_ex_o <= nxt;
        end
    end

endmodule

//--- rtl/mips_execute.sv
`timescale 1ns/1ps

module mips_execute (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                freeze_i,
    input  mips_pkg::id_ex_t    id_ex_i,
    output mips_pkg::fwd_t      ex_fwd_o,
    output logic                ex_load_o,
    output mips_pkg::reg_addr_t ex_load_reg_o,
    output mips_pkg::ex_mem_t   ex_mem_o
);

    mips_pkg::word_t result;

    // ==================================================
    // alu
    // ==================================================
    always_comb begin
        case (id_ex_i.alu_op)
            mips_pkg::ALU_ADD: result = id_ex_i.a + id_ex_i.b;
            mips_pkg::ALU_SUB: result = id_ex_i.a - id_ex_i.b;
            mips_pkg::ALU_AND: result = id_ex_i.a & id_ex_i.b;
            mips_pkg::ALU_OR:  result = id_ex_i.a | id_ex_i.b;
            mips_pkg::ALU_SLT: result = {31'd0, $signed(id_ex_i.a) < $signed(id_ex_i.b)};
            mips_pkg::ALU_LUI: result = {id_ex_i.b[15:0], 16'h0000};
            default:           result = '0;
        endcase
    end

    // a load has no data yet.
    assign ex_fwd_o.we   = id_ex_i.valid && id_ex_i.reg_write && !id_ex_i.mem_read;
    assign ex_fwd_o.addr = id_ex_i.wreg;
    assign ex_fwd_o.data = result;

    assign ex_load_o     = id_ex_i.valid && id_ex_i.mem_read;
    assign ex_load_reg_o = id_ex_i.wreg;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_mem_o.valid     <= 1'b0;
            ex_mem_o.reg_write <= 1'b0;
            ex_mem_o.mem_read  <= 1'b0;
            ex_mem_o.mem_write <= 1'b0;
        end else if (!freeze_i) begin
            ex_mem_o.valid      <= id_ex_i.valid;
            ex_mem_o.pc         <= id_ex_i.pc;
            ex_mem_o.result     <= result;
            ex_mem_o.store_data <= id_ex_i.store_data;
            ex_mem_o.reg_write  <= id_ex_i.reg_write;
            ex_mem_o.wreg       <= id_ex_i.wreg;
            ex_mem_o.mem_read   <= id_ex_i.mem_read;
            ex_mem_o.mem_write  <= id_ex_i.mem_write;
        end
    end

endmodule

//--- rtl/mips_memory.sv
`timescale 1ns/1ps

module mips_memory (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              freeze_i,
    input  mips_pkg::ex_mem_t ex_mem_i,
    input  mips_pkg::word_t   data_rdata_i,
    output logic              data_ren_o,
    output logic [3:0]        data_wen_o,
    output mips_pkg::word_t   data_addr_o,
    output mips_pkg::word_t   data_wdata_o,
    output mips_pkg::fwd_t    mem_fwd_o,
    output mips_pkg::mem_wb_t mem_wb_o
);

    mips_pkg::word_t wb_data;

    // word access only.
    assign data_ren_o   = ex_mem_i.valid && ex_mem_i.mem_read;
    assign data_wen_o   = {4{ex_mem_i.valid && ex_mem_i.mem_write}};
    assign data_addr_o  = ex_mem_i.result;
    assign data_wdata_o = ex_mem_i.store_data;

    assign wb_data = ex_mem_i.mem_read ? data_rdata_i : ex_mem_i.result;

    assign mem_fwd_o.we   = ex_mem_i.valid && ex_mem_i.reg_write;
    assign mem_fwd_o.addr = ex_mem_i.wreg;
    assign mem_fwd_o.data = wb_data;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_wb_o.valid     <= 1'b0;
            mem_wb_o.reg_write <= 1'b0;
        end else if (!freeze_i) begin
            mem_wb_o.valid     <= ex_mem_i.valid;
            mem_wb_o.pc        <= ex_mem_i.pc;
            mem_wb_o.reg_write <= ex_mem_i.reg_write;
            mem_wb_o.wreg      <= ex_mem_i.wreg;
            mem_wb_o.data      <= wb_data;
        end
    end

endmodule

//--- rtl/mips_top.sv
`timescale 1ns/1ps

module mips_top #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc00000
) (
    input  logic                clk,
    input  logic                rst_i,
    output mips_pkg::word_t     inst_sram_addr_o,
    input  mips_pkg::inst_t     inst_sram_rdata_i,
    output logic                data_sram_ren_o,
    output logic [3:0]          data_sram_wen_o,
    output mips_pkg::word_t     data_sram_addr_o,
    output mips_pkg::word_t     data_sram_wdata_o,
    input  mips_pkg::word_t     data_sram_rdata_i,
    input  logic                inst_stall_i,
    input  logic                data_stall_i,
    output logic                debug_wb_valid_o,
    output mips_pkg::word_t     debug_wb_pc_o,
    output logic [3:0]          debug_wb_wen_o,
    output mips_pkg::reg_addr_t debug_wb_num_o,
    output mips_pkg::word_t     debug_wb_data_o
);

    logic                freeze;
    logic                hold;
    logic                branch_taken;
    mips_pkg::word_t     branch_target;
    mips_pkg::word_t     id_pc;
    mips_pkg::inst_t     id_inst;
    logic                id_valid;
    mips_pkg::reg_addr_t rs_addr;
    mips_pkg::reg_addr_t rt_addr;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;
    mips_pkg::fwd_t      ex_fwd;
    mips_pkg::fwd_t      mem_fwd;
    logic                ex_load;
    mips_pkg::reg_addr_t ex_load_reg;
    mips_pkg::id_ex_t    id_ex;
    mips_pkg::ex_mem_t   ex_mem;
    mips_pkg::mem_wb_t   mem_wb;
    logic                wb_we;

    assign freeze = inst_stall_i | data_stall_i;   // whole pipe stops.
    assign wb_we  = mem_wb.valid && mem_wb.reg_write && !freeze;

    assign debug_wb_valid_o = mem_wb.valid;
    assign debug_wb_pc_o    = mem_wb.pc;
    assign debug_wb_wen_o   = {4{mem_wb.valid && mem_wb.reg_write}};
    assign debug_wb_num_o   = mem_wb.wreg;
    assign debug_wb_data_o  = mem_wb.data;

    // ==================================================
    // stages
    // ==================================================
    mips_fetch #(.RESET_PC(RESET_PC)) i_fetch (
        .clk(clk), .rst_i(rst_i), .freeze_i(freeze), .hold_i(hold),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .inst_rdata_i(inst_sram_rdata_i), .inst_addr_o(inst_sram_addr_o),
        .id_pc_o(id_pc), .id_inst_o(id_inst), .id_valid_o(id_valid)
    );

    mips_regfile i_regfile (
        .clk(clk), .rst_i(rst_i), .we_i(wb_we), .waddr_i(mem_wb.wreg),
        .wdata_i(mem_wb.data), .raddr_a_i(rs_addr), .raddr_b_i(rt_addr),
        .rdata_a_o(rs_data), .rdata_b_o(rt_data)
    );

    mips_decode i_decode (
        .clk(clk), .rst_i(rst_i), .freeze_i(freeze), .pc_i(id_pc),
        .inst_i(id_inst), .valid_i(id_valid), .rs_data_i(rs_data), .rt_data_i(rt_data),
        .rs_addr_o(rs_addr), .rt_addr_o(rt_addr), .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd),
        .ex_load_i(ex_load), .ex_load_reg_i(ex_load_reg), .hold_o(hold),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target), .id_ex_o(id_ex)
    );

    mips_execute i_execute (
        .clk(clk), .rst_i(rst_i), .freeze_i(freeze), .id_ex_i(id_ex),
        .ex_fwd_o(ex_fwd), .ex_load_o(ex_load), .ex_load_reg_o(ex_load_reg),
        .ex_mem_o(ex_mem)
    );

    mips_memory i_memory (
        .clk(clk), .rst_i(rst_i), .freeze_i(freeze), .ex_mem_i(ex_mem),
        .data_rdata_i(data_sram_rdata_i), .data_ren_o(data_sram_ren_o),
        .data_wen_o(data_sram_wen_o), .data_addr_o(data_sram_addr_o),
        .data_wdata_o(data_sram_wdata_o), .mem_fwd_o(mem_fwd), .mem_wb_o(mem_wb)
    );

endmodule

//--- test/mips_top_assert.sv
`timescale 1ns/1ps

module mips_top_assert #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc00000
) (
    input logic                clk,
    input logic                rst_i,
    input mips_pkg::word_t     inst_sram_addr_o,
    input mips_pkg::inst_t     inst_sram_rdata_i,
    input logic                data_sram_ren_o,
    input logic [3:0]          data_sram_wen_o,
    input logic                inst_stall_i,
    input logic                data_stall_i,
    input logic                debug_wb_valid_o,
    input mips_pkg::word_t     debug_wb_pc_o,
    input logic [3:0]          debug_wb_wen_o,
    input mips_pkg::reg_addr_t debug_wb_num_o,
    input mips_pkg::word_t     debug_wb_data_o
);

    int                  fail_count = 0;
    logic                retire;
    mips_pkg::inst_t     seen [0:31];     // instruction seen per fetch slot.
    mips_pkg::word_t     model_rf [0:31];
    mips_pkg::word_t     model_mem [0:63];
    mips_pkg::word_t     fetch_off;
    mips_pkg::word_t     cur_off;
    mips_pkg::word_t     cur_pc;
    mips_pkg::word_t     nxt_pc;
    mips_pkg::inst_t     inst;
    mips_pkg::word_t     rs_v;
    mips_pkg::word_t     rt_v;
    mips_pkg::word_t     imm_s;
    mips_pkg::word_t     addr;
    logic                exp_wen;
    mips_pkg::reg_addr_t exp_num;
    mips_pkg::word_t     exp_data;
    logic                taken;

    assign retire    = debug_wb_valid_o && !(inst_stall_i || data_stall_i);
    assign fetch_off = (inst_sram_addr_o - RESET_PC) >> 2;
    assign cur_off   = (cur_pc - RESET_PC) >> 2;

    always_ff @(posedge clk) begin
        if (!rst_i && fetch_off < 32'd32)
            seen[fetch_off[4:0]] <= inst_sram_rdata_i;
    end

    // ==================================================
    // reference instruction model
    // ==================================================
    always_comb begin
        inst     = seen[cur_off[4:0]];
        rs_v     = model_rf[inst[25:21]];
        rt_v     = model_rf[inst[20:16]];
        imm_s    = {{16{inst[15]}}, inst[15:0]};
        addr     = rs_v + imm_s;
        exp_wen  = 1'b1;
        exp_num  = inst[20:16];
        exp_data = '0;
        taken    = 1'b0;
        case (inst[31:26])
            mips_pkg::OP_SPECIAL: begin
                exp_num = inst[15:11];
                case (inst[5:0])
                    mips_pkg::FN_ADDU: exp_data = rs_v + rt_v;
                    mips_pkg::FN_SUBU: exp_data = rs_v - rt_v;
                    mips_pkg::FN_AND:  exp_data = rs_v & rt_v;
                    mips_pkg::FN_OR:   exp_data = rs_v | rt_v;
                    mips_pkg::FN_SLT:  exp_data = {31'd0, $signed(rs_v) < $signed(rt_v)};
                    default:           exp_wen = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: exp_data = addr;
            mips_pkg::OP_ORI:   exp_data = rs_v | {16'h0000, inst[15:0]};
            mips_pkg::OP_LUI:   exp_data = {inst[15:0], 16'h0000};
            mips_pkg::OP_LW:    exp_data = model_mem[addr[7:2]];
            mips_pkg::OP_BEQ: begin
                exp_wen = 1'b0;
                taken   = rs_v == rt_v;
            end
            mips_pkg::OP_BNE: begin
                exp_wen = 1'b0;
                taken   = rs_v != rt_v;
            end
            default: exp_wen = 1'b0;   // sw and anything else.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cur_pc <= RESET_PC;
            nxt_pc <= RESET_PC + 32'd4;
            for (int i = 0; i < 32; i++)
                model_rf[i] <= '0;
            for (int i = 0; i < 64; i++)
                model_mem[i] <= '0;
        end else if (retire) begin
            if (exp_wen && exp_num != 5'd0)
                model_rf[exp_num] <= exp_data;
            if (inst[31:26] == mips_pkg::OP_SW)
                model_mem[addr[7:2]] <= rt_v;
            cur_pc <= nxt_pc;   // delay slot comes next.
            nxt_pc <= taken ? cur_pc + 32'd4 + {imm_s[29:0], 2'b00} : nxt_pc + 32'd4;
        end
    end

    // ==================================================
    // checks
    // ==================================================
    pc_sequence_a: assert property (@(posedge clk) disable iff (rst_i)
        retire |-> debug_wb_pc_o == cur_pc)
    else begin
        fail_count++;
        $error("Error pc_sequence: expected %h, actual %h",
               $sampled(cur_pc), $sampled(debug_wb_pc_o));
    end

    wb_wen_a: assert property (@(posedge clk) disable iff (rst_i)
        retire |-> debug_wb_wen_o == {4{exp_wen}})
    else begin
        fail_count++;
        $error("Error wb_wen: expected %h, actual %h",
               {4{$sampled(exp_wen)}}, $sampled(debug_wb_wen_o));
    end

    wb_data_a: assert property (@(posedge clk) disable iff (rst_i)
        retire && exp_wen |-> debug_wb_num_o == exp_num && debug_wb_data_o == exp_data)
    else begin
        fail_count++;
        $error("Error wb_data: expected r%0d=%h, actual r%0d=%h",
               $sampled(exp_num), $sampled(exp_data),
               $sampled(debug_wb_num_o), $sampled(debug_wb_data_o));
    end

    freeze_hold_a: assert property (@(posedge clk) disable iff (rst_i)
        $past(inst_stall_i || data_stall_i) |-> debug_wb_valid_o == $past(debug_wb_valid_o))
    else begin
        fail_count++;
        $error("Error freeze_hold: expected %b, actual %b",
               $past(debug_wb_valid_o), $sampled(debug_wb_valid_o));
    end

    reset_state_a: assert property (@(posedge clk)
        $past(rst_i) |-> !debug_wb_valid_o && !data_sram_ren_o &&
                         data_sram_wen_o == 4'h0 && inst_sram_addr_o == RESET_PC)
    else begin
        fail_count++;
        $error("Error reset_state: expected idle at pc %h, actual valid %b ren %b wen %h pc %h",
               RESET_PC, $sampled(debug_wb_valid_o), $sampled(data_sram_ren_o),
               $sampled(data_sram_wen_o), $sampled(inst_sram_addr_o));
    end

endmodule

bind mips_top mips_top_assert #(.RESET_PC(RESET_PC)) i_mips_top_assert (.*);

//--- test/tb_mips_top.sv
`timescale 1ns/1ps

module tb_mips_top;

    localparam mips_pkg::word_t RESET_PC   = 32'hbfc00000;
    localparam int              PROG_LEN   = 30;
    localparam int              RST_CYCLES = 5;
    localparam int              CLK_PERIOD = 40;

    logic                clk = 1'b0;
    logic                rst_i;
    logic                inst_stall;
    logic                data_stall;
    mips_pkg::word_t     inst_sram_addr;
    mips_pkg::inst_t     inst_sram_rdata;
    logic                data_sram_ren;
    logic [3:0]          data_sram_wen;
    mips_pkg::word_t     data_sram_addr;
    mips_pkg::word_t     data_sram_wdata;
    mips_pkg::word_t     data_sram_rdata;
    logic                debug_wb_valid;
    mips_pkg::word_t     debug_wb_pc;
    logic [3:0]          debug_wb_wen;
    mips_pkg::reg_addr_t debug_wb_num;
    mips_pkg::word_t     debug_wb_data;

    mips_pkg::inst_t     imem [0:31];
    mips_pkg::word_t     dmem [0:255];
    mips_pkg::word_t     imem_off;
    integer              seed = 32'hd0436f7b;
    int                  retired = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mips_top #(.RESET_PC(RESET_PC)) i_mips_top (
        .clk(clk), .rst_i(rst_i),
        .inst_sram_addr_o(inst_sram_addr), .inst_sram_rdata_i(inst_sram_rdata),
        .data_sram_ren_o(data_sram_ren), .data_sram_wen_o(data_sram_wen),
        .data_sram_addr_o(data_sram_addr), .data_sram_wdata_o(data_sram_wdata),
        .data_sram_rdata_i(data_sram_rdata),
        .inst_stall_i(inst_stall), .data_stall_i(data_stall),
        .debug_wb_valid_o(debug_wb_valid), .debug_wb_pc_o(debug_wb_pc),
        .debug_wb_wen_o(debug_wb_wen), .debug_wb_num_o(debug_wb_num),
        .debug_wb_data_o(debug_wb_data)
    );

    function automatic mips_pkg::inst_t r_type(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [5:0] fn);
        return {mips_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mips_pkg::inst_t i_type(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // ==================================================
    // memories
    // ==================================================
    assign imem_off        = (inst_sram_addr - RESET_PC) >> 2;
    assign inst_sram_rdata = (imem_off < 32'd32) ? imem[imem_off[4:0]] : '0;
    assign data_sram_rdata = data_sram_ren ? dmem[data_sram_addr[9:2]] : '0;

    always @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 256; i++)
                dmem[i] <= '0;
        end else if (data_sram_wen == 4'hf) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
    end

    task automatic load_program();
        for (int i = 0; i < 32; i++)
            imem[i] = '0;   // nop.
        imem[0]  = i_type(mips_pkg::OP_LUI, 5'd0, 5'd1, 16'h1234);
        imem[1]  = i_type(mips_pkg::OP_ORI, 5'd1, 5'd1, 16'h5678);     // execute bypass.
        imem[2]  = i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd2, 16'h0005);
        imem[3]  = i_type(mips_pkg::OP_ADDIU, 5'd2, 5'd3, 16'hfffe);
        imem[4]  = r_type(5'd1, 5'd3, 5'd4, mips_pkg::FN_ADDU);
        imem[5]  = r_type(5'd4, 5'd2, 5'd5, mips_pkg::FN_SUBU);
        imem[6]  = r_type(5'd5, 5'd1, 5'd6, mips_pkg::FN_AND);
        imem[7]  = r_type(5'd6, 5'd3, 5'd7, mips_pkg::FN_OR);
        imem[8]  = r_type(5'd3, 5'd2, 5'd8, mips_pkg::FN_SLT);
        imem[9]  = r_type(5'd2, 5'd3, 5'd9, mips_pkg::FN_SLT);
        imem[10] = i_type(mips_pkg::OP_SW, 5'd0, 5'd7, 16'h0008);
        imem[11] = i_type(mips_pkg::OP_LW, 5'd0, 5'd10, 16'h0008);
        imem[12] = r_type(5'd10, 5'd10, 5'd11, mips_pkg::FN_ADDU);      // load-use.
        imem[13] = i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h0007);
        imem[14] = r_type(5'd0, 5'd11, 5'd12, mips_pkg::FN_ADDU);
        imem[15] = i_type(mips_pkg::OP_BEQ, 5'd8, 5'd8, 16'h0002);
        imem[16] = i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd13, 16'h0001);
        imem[17] = i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd13, 16'h0063);  // skipped.
        imem[18] = i_type(mips_pkg::OP_BNE, 5'd9, 5'd0, 16'h0005);
        imem[19] = i_type(mips_pkg::OP_ORI, 5'd0, 5'd14, 16'h00ff);
        imem[20] = r_type(5'd0, 5'd14, 5'd15, mips_pkg::FN_SUBU);
        imem[21] = r_type(5'd15, 5'd0, 5'd16, mips_pkg::FN_SLT);
        imem[22] = i_type(mips_pkg::OP_SW, 5'd0, 5'd15, 16'h000c);
        imem[23] = i_type(mips_pkg::OP_LW, 5'd0, 5'd17, 16'h000c);
        imem[24] = i_type(mips_pkg::OP_BEQ, 5'd17, 5'd15, 16'h0002);    // branch on load.
        imem[26] = i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd18, 16'h0001);
        imem[27] = i_type(mips_pkg::OP_ADDIU, 5'd17, 5'd19, 16'h0001);
        imem[28] = i_type(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'hffff);      // spin here.
    endtask

    // ==================================================
    // stimulus and run control
    // ==================================================
    initial begin
        rst_i      = 1'b1;
        inst_stall = 1'b0;
        data_stall = 1'b0;
        load_program();
        repeat (RST_CYCLES) @(negedge clk);
        rst_i = 1'b0;
        forever begin
            @(negedge clk);
            inst_stall = ($random(seed) & 3) == 0;
            data_stall = ($random(seed) & 3) == 0;
        end
    end

    // a retirement is consumed on an edge without freeze.
    always @(posedge clk) begin
        if (!rst_i && debug_wb_valid && !(inst_stall || data_stall))
            retired <= retired + 1;
    end

    always @(negedge clk) begin
        if (i_mips_top.i_mips_top_assert.fail_count != 0) begin
            $display("sim failed");
            $fatal(1, "retirement check failed at %0t", $time);
        end
    end

    initial begin
        wait (retired == PROG_LEN);
        @(negedge clk);
        if (i_mips_top.i_mips_top_assert.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "retirement checks failed");
        end
    end

    initial begin
        repeat (PROG_LEN * 8 + RST_CYCLES) @(posedge clk);
        $display("sim failed");
        $fatal(1, "timeout, retirement stalled after %0d of %0d", retired, PROG_LEN);
    end

endmodule

//--- project.f
rtl/mips_pkg.sv
rtl/mips_fetch.sv
rtl/mips_regfile.sv
rtl/mips_decode.sv
rtl/mips_execute.sv
rtl/mips_memory.sv
rtl/mips_top.sv
test/mips_top_assert.sv
test/tb_mips_top.sv

//--- Makefile
TOP := tb_mips_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir
